//--- common/rvPkg.sv
`default_nettype none

package rvPkg;

    // Data path width
    localparam int xlen = 32;

    // Major opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLui    = 7'b0110111;

    // ALU operations
    typedef enum logic [3:0] {
        aluAdd   = 4'b0000,
        aluSub   = 4'b0001,
        aluAnd   = 4'b0010,
        aluOr    = 4'b0011,
        aluXor   = 4'b0100,
        aluSll   = 4'b0101,
        aluSrl   = 4'b0110,
        aluSra   = 4'b0111,
        aluSlt   = 4'b1000,
        aluSltu  = 4'b1001,
        aluPassB = 4'b1010
    } aluOp;

    // Immediate formats
    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immU = 2'b11
    } immSel;

    // Decoder outputs to the core
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;     // 1 selects the immediate as operand B
        logic  memWrite;
        logic  resultSrc;  // 1 selects load data for writeback
        immSel immSrc;
        aluOp  aluCtrl;
        logic  pcSrc;      // 1 takes the branch target
    } ctrlSignals;

endpackage

`default_nettype wire

//--- cpu/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rvPkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOp            op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;

    // Only the low five bits count as shift amount
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $unsigned($signed(a) >>> shamt);
            aluSlt:   result = {{(xlen - 1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu:  result = {{(xlen - 1){1'b0}}, a < b};
            // LUI goes through here
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- cpu/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import rvPkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  logic       zero,
    output ctrlSignals ctrl
);

    always_comb begin
        // Inactive defaults, unknown opcodes leave state untouched
        ctrl.regWrite  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.resultSrc = 1'b0;
        ctrl.immSrc    = immI;
        ctrl.aluCtrl   = aluAdd;
        ctrl.pcSrc     = 1'b0;

        case (opcode)
            opR: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluCtrl = funct7[5] ? aluSub : aluAdd;
                    3'b001: ctrl.aluCtrl = aluSll;
                    3'b010: ctrl.aluCtrl = aluSlt;
                    3'b011: ctrl.aluCtrl = aluSltu;
                    3'b100: ctrl.aluCtrl = aluXor;
                    3'b101: ctrl.aluCtrl = funct7[5] ? aluSra : aluSrl;
                    3'b110: ctrl.aluCtrl = aluOr;
                    3'b111: ctrl.aluCtrl = aluAnd;
                    default: ctrl.aluCtrl = aluAdd;
                endcase
            end

            opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immI;
                // No SUBI, so funct7 only matters for the right shifts
                case (funct3)
                    3'b000: ctrl.aluCtrl = aluAdd;
                    3'b001: ctrl.aluCtrl = aluSll;
                    3'b010: ctrl.aluCtrl = aluSlt;
                    3'b011: ctrl.aluCtrl = aluSltu;
                    3'b100: ctrl.aluCtrl = aluXor;
                    3'b101: ctrl.aluCtrl = funct7[5] ? aluSra : aluSrl;
                    3'b110: ctrl.aluCtrl = aluOr;
                    3'b111: ctrl.aluCtrl = aluAnd;
                    default: ctrl.aluCtrl = aluAdd;
                endcase
            end

            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = 1'b1;
                ctrl.immSrc    = immI;
                ctrl.aluCtrl   = aluAdd;
            end

            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immS;
                ctrl.aluCtrl  = aluAdd;
            end

            opBranch: begin
                ctrl.immSrc = immB;
                // Every compare reduces to the zero flag
                case (funct3)
                    3'b000: begin
                        ctrl.aluCtrl = aluSub;
                        ctrl.pcSrc   = zero;
                    end
                    3'b001: begin
                        ctrl.aluCtrl = aluSub;
                        ctrl.pcSrc   = ~zero;
                    end
                    // slt gives 1 when less, so zero clear means taken
                    3'b100: begin
                        ctrl.aluCtrl = aluSlt;
                        ctrl.pcSrc   = ~zero;
                    end
                    3'b101: begin
                        ctrl.aluCtrl = aluSlt;
                        ctrl.pcSrc   = zero;
                    end
                    3'b110: begin
                        ctrl.aluCtrl = aluSltu;
                        ctrl.pcSrc   = ~zero;
                    end
                    3'b111: begin
                        ctrl.aluCtrl = aluSltu;
                        ctrl.pcSrc   = zero;
                    end
                    default: ctrl.pcSrc = 1'b0;
                endcase
            end

            opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immU;
                ctrl.aluCtrl  = aluPassB;
            end

            default: ;
        endcase
    end

    // A store never writes back, so the memory and register commits stay exclusive
    always_comb begin
        assert (!(ctrl.memWrite && ctrl.regWrite))
            else $error("controlUnit: memWrite and regWrite both set");
    end

endmodule

`default_nettype wire

//--- cpu/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    output logic [xlen-1:0] pc,
    input  logic [31:0]     instr,
    output logic            dmemWe,
    output logic [xlen-1:0] dmemAddr,
    output logic [xlen-1:0] dmemWdata,
    input  logic [xlen-1:0] dmemRdata
);

    // ADDI x0, x0, 0
    localparam logic [31:0] nopInstr = {12'b0, 5'b0, 3'b000, 5'b0, opImm};

    logic [31:0]     instrDec;
    ctrlSignals      ctrl;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluResult;
    logic            zero;
    logic [xlen-1:0] result;
    logic [xlen-1:0] pcNext;

    // Held in reset, the decoder sees a NOP so no store can leak out
    assign instrDec = rstN ? instr : nopInstr;

    controlUnit uCtrl (
        .opcode (instrDec[6:0]),
        .funct3 (instrDec[14:12]),
        .funct7 (instrDec[31:25]),
        .zero   (zero),
        .ctrl   (ctrl)
    );

    regFile uRegs (
        .clk  (clk),
        .rstN (rstN),
        .rs1  (instrDec[19:15]),
        .rs2  (instrDec[24:20]),
        .rd   (instrDec[11:7]),
        .we   (ctrl.regWrite),
        .wd   (result),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    immGen uImm (
        .instr (instrDec),
        .sel   (ctrl.immSrc),
        .imm   (imm)
    );

    assign srcB = ctrl.aluSrc ? imm : rd2;

    alu uAlu (
        .a      (rd1),
        .b      (srcB),
        .op     (ctrl.aluCtrl),
        .result (aluResult),
        .zero   (zero)
    );

    assign dmemWe    = ctrl.memWrite;
    assign dmemAddr  = aluResult;
    assign dmemWdata = rd2;

    assign result = ctrl.resultSrc ? dmemRdata : aluResult;

    // imm holds the B offset whenever pcSrc can be set
    assign pcNext = ctrl.pcSrc ? pc + imm : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // Every committed instruction leaves the next PC on a word boundary
    assert property (@(posedge clk) rstN |=> pc[1:0] == 2'b00)
        else $error("cpuCore: PC misaligned 0x%08h", pc);

endmodule

`default_nettype wire

//--- cpu/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen import rvPkg::*; (
    input  logic [31:0]     instr,
    input  immSel           sel,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (sel)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offsets are in halfwords, bit 0 always clear
            immB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
            immU: imm = {instr[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- cpu/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            we,
    input  logic [xlen-1:0] wd,
    output logic [xlen-1:0] rd1,
    output logic [xlen-1:0] rd2
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    // Combinational reads straight from storage
    // x0 keeps its reset value because writes to it are dropped
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // x0 reads zero on both ports, whatever was written to it before
    assert property (@(posedge clk) disable iff (!rstN)
        (rs1 != 5'd0 || rd1 == '0) && (rs2 != 5'd0 || rd2 == '0))
        else $error("regFile: x0 read back nonzero");

endmodule

`default_nettype wire

//--- files.f
common/rvPkg.sv
cpu/controlUnit.sv
cpu/alu.sv
cpu/regFile.sv
cpu/immGen.sv
cpu/cpuCore.sv
hdl/instrMem.sv
hdl/dataMem.sv
hdl/cpuTop.sv
tests/clockGen.sv
tests/cpuTb.sv

//--- hdl/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import rvPkg::*; #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            progWe,
    input  logic [xlen-1:0] progAddr,
    input  logic [31:0]     progData,
    output logic            dmemWe,
    output logic [xlen-1:0] dmemAddr,
    output logic [xlen-1:0] dmemWdata
);

    logic [xlen-1:0] pc;
    logic [31:0]     instr;
    logic [xlen-1:0] dmemRdata;

    cpuCore uCore (
        .clk       (clk),
        .rstN      (rstN),
        .pc        (pc),
        .instr     (instr),
        .dmemWe    (dmemWe),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemRdata (dmemRdata)
    );

    instrMem #(
        .imemDepth (imemDepth)
    ) uImem (
        .clk      (clk),
        .rstN     (rstN),
        .addr     (pc),
        .instr    (instr),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData)
    );

    // Store bus is shared with the top-level outputs
    dataMem #(
        .dmemDepth (dmemDepth)
    ) uDmem (
        .clk   (clk),
        .we    (dmemWe),
        .addr  (dmemAddr),
        .wdata (dmemWdata),
        .rdata (dmemRdata)
    );

endmodule

`default_nettype wire

//--- hdl/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem import rvPkg::*; #(
    parameter int dmemDepth = 256
) (
    input  logic            clk,
    input  logic            we,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata
);

    localparam int idxW = $clog2(dmemDepth);

    logic [xlen-1:0] mem [dmemDepth];
    logic [idxW-1:0] wordIdx;

    // Byte address down to word index, low bits dropped
    assign wordIdx = addr[idxW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    assign rdata = mem[wordIdx];

endmodule

`default_nettype wire

//--- hdl/instrMem.sv
`timescale 1ns/1ps
`default_nettype none

module instrMem import rvPkg::*; #(
    parameter int imemDepth = 256
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic [xlen-1:0] addr,
    output logic [31:0]     instr,
    input  logic            progWe,
    input  logic [xlen-1:0] progAddr,
    input  logic [31:0]     progData
);

    localparam int idxW = $clog2(imemDepth);

    logic [31:0] mem [imemDepth];

    // Program load, only accepted while the core is held in reset
    always_ff @(posedge clk) begin
        if (!rstN && progWe) begin
            mem[progAddr[idxW+1:2]] <= progData;
        end
    end

    assign instr = mem[addr[idxW+1:2]];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module cpuTb -o cpuSim
./obj_dir/cpuSim > sim.log
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1

//--- tests/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod = 50
) (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #(halfPeriod) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tests/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int resetCycles = 10;
    localparam int progLimit   = 400;
    // Six programs of up to 400 cycles, plus loading and reset
    localparam int cycleLimit  = 6 * progLimit + 600;

    localparam int opR      = 'h33;
    localparam int opImm    = 'h13;
    localparam int opLoad   = 'h03;
    localparam int opStore  = 'h23;
    localparam int opBranch = 'h63;
    localparam int opLui    = 'h37;
    // BEQ x0, x0, 0 closes every program
    localparam logic [31:0] selfLoop = 32'h00000063;

    logic        clk;
    logic        rstN;
    logic        progWe;
    logic [31:0] progAddr;
    logic [31:0] progData;
    logic        dmemWe;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;

    int          checks;
    int          errors;
    int          cycles;
    logic [31:0] prog [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] gotAddr [$];
    logic [31:0] gotData [$];
    logic [31:0] refRegs [32];
    logic [31:0] refMem [logic [31:0]];

    clockGen uClk (
        .clk (clk)
    );

    cpuTop #(
        .imemDepth (256),
        .dmemDepth (256)
    ) UUT (
        .clk       (clk),
        .rstN      (rstN),
        .progWe    (progWe),
        .progAddr  (progAddr),
        .progData  (progData),
        .dmemWe    (dmemWe),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata)
    );

    function automatic logic [31:0] encR(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] encI(input int op, input int f3, input int rd,
                                         input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] encS(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input int f3, input int rs1, input int rs2,
                                         input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'h37};
    endfunction

    // Index order ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    function automatic logic [31:0] rOp(input int k, input int rd, input int rs1,
                                        input int rs2);
        int f3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        return encR((k == 1 || k == 7) ? 32 : 0, f3[k], rd, rs1, rs2);
    endfunction

    function automatic logic signedLess(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, signedLess(a, b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            // Arithmetic shift fills the vacated bits with the sign
            3'd5: return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hFFFFFFFF >> b[4:0]) : 32'd0);
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return signedLess(a, b);
            3'd5: return !signedLess(a, b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Instruction set model, runs the program up to its final loop
    task automatic runModel(output int steps);
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nextPc;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        steps = 0;
        pc = '0;
        refMem.delete();
        expAddr.delete();
        expData.delete();
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        while (steps < progLimit && prog[pc >> 2] != selfLoop) begin
            ins = prog[pc >> 2];
            a = refRegs[ins[19:15]];
            b = refRegs[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            nextPc = pc + 32'd4;
            case (ins[6:0])
                opR[6:0]: refRegs[ins[11:7]] = aluRef(ins[14:12], ins[30], a, b);
                opImm[6:0]: refRegs[ins[11:7]] =
                    aluRef(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, immI);
                opLoad[6:0]: refRegs[ins[11:7]] = refMem[a + immI];
                opStore[6:0]: begin
                    refMem[a + immS] = b;
                    expAddr.push_back(a + immS);
                    expData.push_back(b);
                end
                opBranch[6:0]: if (branchTaken(ins[14:12], a, b)) nextPc = pc + immB;
                opLui[6:0]: refRegs[ins[11:7]] = {ins[31:12], 12'd0};
                default: ;
            endcase
            refRegs[0] = '0;
            pc = nextPc;
            steps++;
        end
        if (steps >= progLimit) begin
            errors++;
            $display("Model never reached the final loop within %0d steps", progLimit);
        end
    endtask

    task automatic addInstr(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic loadConst(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        // Round up so the sign-extended low part lands on the value
        upper = (value + 32'h800) >> 12;
        addInstr(encU(rd, upper));
        addInstr(encI(opImm, 0, rd, rd, value));
    endtask

    task automatic runProgram(input string name);
        int steps;
        addInstr(selfLoop);
        runModel(steps);
        @(posedge clk);
        #1;
        rstN = 1'b0;
        foreach (prog[i]) begin
            progWe = 1'b1;
            progAddr = i * 4;
            progData = prog[i];
            @(posedge clk);
            #1;
        end
        progWe = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        gotAddr.delete();
        gotData.delete();
        for (int c = 0; c <= steps; c++) begin
            @(negedge clk);
            if (dmemWe) begin
                gotAddr.push_back(dmemAddr);
                gotData.push_back(dmemWdata);
            end
            @(posedge clk);
            #1;
        end
        checks++;
        if (gotAddr.size() != expAddr.size()) begin
            errors++;
            $display("%s: %0d stores expected but %0d seen", name, expAddr.size(),
                     gotAddr.size());
        end
        for (int i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
            checks++;
            if (gotAddr[i] !== expAddr[i]) begin
                errors++;
                $display("ERROR %s store %0d dmemAddr expected 0x%08h got 0x%08h", name, i,
                         expAddr[i], gotAddr[i]);
            end
            if (gotData[i] !== expData[i]) begin
                errors++;
                $display("ERROR %s store %0d dmemWdata expected 0x%08h got 0x%08h", name, i,
                         expData[i], gotData[i]);
            end
        end
        prog.delete();
    endtask

    task automatic rTypeOps();
        int slot;
        slot = 0;
        loadConst(1, 32'hFFFFFFF9);
        loadConst(2, 32'h12345678);
        // Shift amount 35 only uses its low five bits
        loadConst(3, 35);
        loadConst(4, 32'h80000000);
        for (int k = 0; k < 10; k++) begin
            addInstr(rOp(k, 5, 1, 2));
            addInstr(rOp(k, 6, 2, 1));
            addInstr(rOp(k, 7, 4, 3));
            addInstr(encS(5, 0, slot));
            addInstr(encS(6, 0, slot + 4));
            addInstr(encS(7, 0, slot + 8));
            slot += 12;
        end
        runProgram("R-type");
    endtask

    task automatic iTypeOps();
        loadConst(1, -100);
        loadConst(2, 32'h0F0F00FF);
        loadConst(4, 32'h80000000);
        addInstr(encI(opImm, 0, 5, 1, -5));
        addInstr(encI(opImm, 0, 6, 2, -2048));
        addInstr(encI(opImm, 7, 7, 2, 'hF0F));
        addInstr(encI(opImm, 6, 8, 1, 'h7FF));
        addInstr(encI(opImm, 4, 9, 2, -1));
        addInstr(encI(opImm, 2, 10, 1, -99));
        addInstr(encI(opImm, 2, 11, 1, -101));
        addInstr(encI(opImm, 3, 12, 1, 5));
        addInstr(encI(opImm, 3, 13, 2, -1));
        addInstr(encI(opImm, 1, 14, 2, 4));
        addInstr(encI(opImm, 5, 15, 1, 28));
        addInstr(encI(opImm, 5, 16, 1, 'h403));
        addInstr(encI(opImm, 5, 17, 4, 'h41F));
        for (int r = 5; r <= 17; r++) begin
            addInstr(encS(r, 0, (r - 5) * 4));
        end
        runProgram("I-type");
    endtask

    task automatic loadStoreRoundTrip();
        loadConst(1, 32'hDEADBEEF);
        loadConst(2, 32'h13579BDF);
        loadConst(3, -1);
        loadConst(10, 'h100);
        addInstr(encS(1, 10, 0));
        addInstr(encS(2, 10, 8));
        addInstr(encS(3, 10, -4));
        addInstr(encI(opLoad, 2, 5, 10, 0));
        addInstr(encI(opLoad, 2, 6, 10, 8));
        addInstr(encI(opLoad, 2, 7, 10, -4));
        addInstr(encS(5, 10, 64));
        addInstr(encS(6, 10, 72));
        addInstr(encS(7, 10, 60));
        addInstr(rOp(0, 8, 5, 6));
        addInstr(encS(8, 10, 128));
        addInstr(encI(opLoad, 2, 9, 10, 64));
        addInstr(encS(9, 10, 200));
        runProgram("LW/SW");
    endtask

    task automatic branchPaths();
        // funct3, rs1, rs2: a taken and a not-taken case per type
        int cases [12][3] = '{'{0, 2, 3}, '{0, 1, 2}, '{1, 1, 2}, '{1, 2, 3},
                              '{4, 1, 2}, '{4, 2, 1}, '{5, 2, 1}, '{5, 4, 2},
                              '{6, 2, 1}, '{6, 1, 2}, '{7, 1, 4}, '{7, 4, 1}};
        loadConst(1, 32'hFFFFFFFF);
        loadConst(2, 1);
        loadConst(3, 1);
        loadConst(4, 32'h80000000);
        for (int i = 0; i < 12; i++) begin
            addInstr(encI(opImm, 0, 20, 0, i + 1));
            addInstr(encI(opImm, 0, 21, 0, 256 + i));
            // Taken skips the fall-through marker
            addInstr(encB(cases[i][0], cases[i][1], cases[i][2], 8));
            addInstr(encS(20, 0, i * 8));
            addInstr(encS(21, 0, i * 8 + 4));
        end
        runProgram("branch");
    endtask

    task automatic luiAndZeroReg();
        addInstr(encU(1, 'hABCDE));
        addInstr(encS(1, 0, 0));
        addInstr(encU(2, 'h80000));
        addInstr(encI(opImm, 0, 2, 2, -1));
        addInstr(encS(2, 0, 4));
        addInstr(encU(3, 'hFFFFF));
        addInstr(encI(opImm, 0, 3, 3, 'h7FF));
        addInstr(encS(3, 0, 8));
        addInstr(encI(opImm, 0, 0, 0, 5));
        addInstr(encS(0, 0, 12));
        addInstr(encU(0, 'h12345));
        addInstr(encS(0, 0, 16));
        addInstr(rOp(0, 0, 1, 2));
        addInstr(encS(0, 0, 20));
        runProgram("LUI/x0");
    endtask

    task automatic randomROps();
        logic [31:0] a;
        logic [31:0] b;
        int          k;
        for (int i = 0; i < 20; i++) begin
            a = $urandom;
            b = $urandom;
            k = $urandom_range(9, 0);
            loadConst(1, a);
            loadConst(2, b);
            addInstr(rOp(k, 5, 1, 2));
            addInstr(encS(5, 0, i * 4));
        end
        runProgram("random");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(33));
        checks = 0;
        errors = 0;
        cycles = 0;
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rTypeOps();
        iTypeOps();
        loadStoreRoundTrip();
        branchPaths();
        luiAndZeroReg();
        randomROps();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
